// File: hdl/alu_unit.sv
// 64-bit integer alu of the execute stage
`timescale 1ns/1ps

module alu_unit (
    input  pipe_pkg::id_ex_t id_ex_i,
    output pipe_pkg::ex_wb_t ex_wb_o
);

    logic [rv_isa_pkg::XLEN-1:0] a;
    logic [rv_isa_pkg::XLEN-1:0] b;
    logic [5:0]                  shamt;
    logic [rv_isa_pkg::XLEN-1:0] result;

    assign a     = id_ex_i.op_a;
    assign b     = id_ex_i.op_b;
    assign shamt = b[5:0];

    always_comb begin
        case (id_ex_i.alu_op)
            rv_isa_pkg::ALU_ADD:    result = a + b;
            rv_isa_pkg::ALU_SUB:    result = a - b;
            rv_isa_pkg::ALU_SLL:    result = a << shamt;
            rv_isa_pkg::ALU_SLT:    result = {63'b0, $signed(a) < $signed(b)};
            rv_isa_pkg::ALU_SLTU:   result = {63'b0, a < b};
            rv_isa_pkg::ALU_XOR:    result = a ^ b;
            rv_isa_pkg::ALU_SRL:    result = a >> shamt;
            rv_isa_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            rv_isa_pkg::ALU_OR:     result = a | b;
            rv_isa_pkg::ALU_AND:    result = a & b;
            rv_isa_pkg::ALU_PASS_B: result = b; // lui immediate
            default:                result = '0;
        endcase
    end

    assign ex_wb_o.pc      = id_ex_i.pc;
    assign ex_wb_o.rd      = id_ex_i.rd;
    assign ex_wb_o.result  = result;
    assign ex_wb_o.reg_we  = id_ex_i.reg_we;
    assign ex_wb_o.illegal = id_ex_i.illegal;

endmodule

// File: hdl/decode_unit.sv
// instruction decode with immediate generation and operand forwarding
`timescale 1ns/1ps

module decode_unit (
    input  logic                              fetch_valid_i,
    input  pipe_pkg::fetch_t                  fetch_i,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [rv_isa_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_isa_pkg::XLEN-1:0]       rs2_data_i,
    input  pipe_pkg::ex_wb_t                  ex_fwd_i,
    input  logic                              ex_valid_i,
    input  pipe_pkg::ex_wb_t                  wb_fwd_i,
    input  logic                              wb_valid_i,
    output logic                              id_valid_o,
    output pipe_pkg::id_ex_t                  id_ex_o
);

    logic [rv_isa_pkg::INST_W-1:0]     inst;
    logic [6:0]                        opcode;
    logic [2:0]                        funct3;
    logic [6:0]                        funct7;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]       imm_i;
    logic [rv_isa_pkg::XLEN-1:0]       imm_u;
    logic                              alt;
    logic                              alt6;
    rv_isa_pkg::alu_op_e               alu_op;
    logic                              illegal;
    logic [rv_isa_pkg::XLEN-1:0]       rs1_val;
    logic [rv_isa_pkg::XLEN-1:0]       rs2_val;
    logic [rv_isa_pkg::XLEN-1:0]       op_b;

    assign inst       = fetch_i.inst;
    assign opcode     = inst[rv_isa_pkg::OPC_LSB +: 7];
    assign funct3     = inst[rv_isa_pkg::F3_LSB +: 3];
    assign funct7     = inst[rv_isa_pkg::F7_LSB +: 7];
    assign rd         = inst[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_ADDR_W];
    assign rs1_addr_o = inst[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_ADDR_W];
    assign rs2_addr_o = inst[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_ADDR_W];
    assign imm_i      = {{52{inst[31]}}, inst[31:20]};
    assign imm_u      = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign alt        = (funct7 == rv_isa_pkg::FUNCT7_ALT);
    assign alt6       = (funct7[6:1] == rv_isa_pkg::FUNCT7_ALT[6:1]); // rv64 shamt is 6 bits

    // youngest producer wins: execute, then writeback, then register file
    function automatic logic [rv_isa_pkg::XLEN-1:0] fwd_sel(
        input logic [rv_isa_pkg::REG_ADDR_W-1:0] addr,
        input logic [rv_isa_pkg::XLEN-1:0]       rf_data
    );
        if (ex_valid_i && ex_fwd_i.reg_we && ex_fwd_i.rd != '0 && ex_fwd_i.rd == addr)
            return ex_fwd_i.result;
        else if (wb_valid_i && wb_fwd_i.reg_we && !wb_fwd_i.illegal &&
                 wb_fwd_i.rd != '0 && wb_fwd_i.rd == addr)
            return wb_fwd_i.result;
        else
            return rf_data;
    endfunction

    always_comb begin
        alu_op  = rv_isa_pkg::ALU_ADD;
        illegal = 1'b0;
        op_b    = rs2_val;
        case (opcode)
            rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: alu_op = (alt && opcode == rv_isa_pkg::OPC_OP) ?
                                                     rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SLL:     alu_op = rv_isa_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SLT:     alu_op = rv_isa_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU:    alu_op = rv_isa_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_XOR:     alu_op = rv_isa_pkg::ALU_XOR;
                    rv_isa_pkg::F3_SRL_SRA: alu_op = inst[30] ? rv_isa_pkg::ALU_SRA
                                                              : rv_isa_pkg::ALU_SRL;
                    rv_isa_pkg::F3_OR:      alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:     alu_op = rv_isa_pkg::ALU_AND;
                endcase
                if (opcode == rv_isa_pkg::OPC_OP) begin
                    // funct7 must be zero, alt only for sub and sra
                    illegal = !(funct7 == '0 || (alt && (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                                                         funct3 == rv_isa_pkg::F3_SRL_SRA)));
                end else begin
                    op_b = imm_i;
                    if (funct3 == rv_isa_pkg::F3_SLL)
                        illegal = (funct7[6:1] != '0);
                    else if (funct3 == rv_isa_pkg::F3_SRL_SRA)
                        illegal = !(funct7[6:1] == '0 || alt6);
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                alu_op = rv_isa_pkg::ALU_PASS_B;
                op_b   = imm_u;
            end
            default: illegal = 1'b1; // unknown opcode
        endcase
    end

    always_comb begin
        rs1_val = fwd_sel(rs1_addr_o, rs1_data_i);
        rs2_val = fwd_sel(rs2_addr_o, rs2_data_i);
    end

    assign id_valid_o      = fetch_valid_i;
    assign id_ex_o.pc      = fetch_i.pc;
    assign id_ex_o.alu_op  = alu_op;
    assign id_ex_o.op_a    = rs1_val;
    assign id_ex_o.op_b    = op_b;
    assign id_ex_o.rd      = illegal ? '0 : rd; // illegal retires with rd zero
    assign id_ex_o.reg_we  = !illegal;
    assign id_ex_o.illegal = illegal;

endmodule

// File: hdl/fetch_unit.sv
// program counter and four-phase req/ack instruction fetch sequencer
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic                          clk,
    input  logic                          reset_i,
    output logic                          imem_req_o,
    output logic [rv_isa_pkg::XLEN-1:0]   imem_addr_o,
    input  logic                          imem_ack_i,
    input  logic [rv_isa_pkg::INST_W-1:0] imem_rdata_i,
    output logic                          fetch_valid_o,
    output pipe_pkg::fetch_t              fetch_o
);

    typedef enum logic [1:0] {
        S_REQ,  // launch a request
        S_ACK,  // req high, waiting for ack
        S_REL   // req low, waiting for ack to drop
    } phase_e;

    phase_e                      state;
    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic                        capture;

    assign capture     = (state == S_ACK) && imem_ack_i;
    assign imem_req_o  = (state == S_ACK);
    assign imem_addr_o = pc; // only moves on capture, req is low then

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= S_REQ;
            pc            <= RESET_PC;
            fetch_valid_o <= 1'b0;
            fetch_o       <= '{pc: RESET_PC, inst: rv_isa_pkg::NOP_INST};
        end else begin
            fetch_valid_o <= capture; // one-cycle pulse
            case (state)
                S_REQ: state <= S_ACK;
                S_ACK: begin
                    if (imem_ack_i) begin
                        fetch_o.pc   <= pc;
                        fetch_o.inst <= imem_rdata_i;
                        pc           <= pc + rv_isa_pkg::XLEN'(4);
                        state        <= S_REL;
                    end
                end
                S_REL: begin
                    if (!imem_ack_i) begin
                        state <= S_ACK; // ack released, next word
                    end
                end
                default: state <= S_REQ;
            endcase
        end
    end

endmodule

// File: hdl/pipe_pkg.sv
// stage payloads and the retire record of the integer core
package pipe_pkg;

    // fetch -> decode
    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]   pc;
        logic [rv_isa_pkg::INST_W-1:0] inst;
    } fetch_t;

    // decode -> execute, operands already forwarded
    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        rv_isa_pkg::alu_op_e               alu_op;
        logic [rv_isa_pkg::XLEN-1:0]       op_a;
        logic [rv_isa_pkg::XLEN-1:0]       op_b;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
        logic                              reg_we;
        logic                              illegal;
    } id_ex_t;

    // execute -> writeback
    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
        logic [rv_isa_pkg::XLEN-1:0]       result;
        logic                              reg_we;
        logic                              illegal;
    } ex_wb_t;

    // retire record
    typedef struct packed {
        logic                              valid;
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
        logic [rv_isa_pkg::XLEN-1:0]       wdata;
        logic                              illegal;
    } commit_t;

endpackage

// File: hdl/reg_file.sv
// 32 x 64-bit integer register file, two read ports, one write port
`timescale 1ns/1ps

module reg_file (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_isa_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_isa_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                              we_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]       wdata_i
);

    logic [rv_isa_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 always reads zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: hdl/rv_core_top.sv
// in-order rv64i integer core: fetch, decode, execute and writeback
`timescale 1ns/1ps

module rv_core_top #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic                          clk,
    input  logic                          reset_i,
    output logic                          imem_req_o,
    output logic [rv_isa_pkg::XLEN-1:0]   imem_addr_o,
    input  logic                          imem_ack_i,
    input  logic [rv_isa_pkg::INST_W-1:0] imem_rdata_i,
    output pipe_pkg::commit_t             commit_o
);

    logic                              fetch_valid;
    pipe_pkg::fetch_t                  fetch;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_isa_pkg::XLEN-1:0]       rs1_data;
    logic [rv_isa_pkg::XLEN-1:0]       rs2_data;
    logic                              id_valid;
    pipe_pkg::id_ex_t                  id_ex;
    logic                              ex_valid;
    pipe_pkg::id_ex_t                  ex_in;
    pipe_pkg::ex_wb_t                  ex_res;
    logic                              wb_valid;
    pipe_pkg::ex_wb_t                  wb;
    logic                              rf_we;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset_i(reset_i),
        .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o),
        .imem_ack_i(imem_ack_i), .imem_rdata_i(imem_rdata_i),
        .fetch_valid_o(fetch_valid), .fetch_o(fetch)
    );

    decode_unit u_decode (
        .fetch_valid_i(fetch_valid), .fetch_i(fetch),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_fwd_i(ex_res), .ex_valid_i(ex_valid),
        .wb_fwd_i(wb), .wb_valid_i(wb_valid),
        .id_valid_o(id_valid), .id_ex_o(id_ex)
    );

    reg_file u_rf (
        .clk(clk), .reset_i(reset_i),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rf_we), .waddr_i(wb.rd), .wdata_i(wb.result)
    );

    stage_reg #(.payload_t(pipe_pkg::id_ex_t)) u_id_ex (
        .clk(clk), .reset_i(reset_i),
        .valid_i(id_valid), .data_i(id_ex),
        .valid_o(ex_valid), .data_o(ex_in)
    );

    alu_unit u_alu (.id_ex_i(ex_in), .ex_wb_o(ex_res));

    stage_reg #(.payload_t(pipe_pkg::ex_wb_t)) u_ex_wb (
        .clk(clk), .reset_i(reset_i),
        .valid_i(ex_valid), .data_i(ex_res),
        .valid_o(wb_valid), .data_o(wb)
    );

    // writeback and retire
    assign rf_we = wb_valid && wb.reg_we && !wb.illegal && (wb.rd != '0);

    assign commit_o.valid   = wb_valid;
    assign commit_o.pc      = wb.pc;
    assign commit_o.rd      = wb.rd;
    assign commit_o.wdata   = (wb.rd == '0) ? '0 : wb.result; // x0 retires zero
    assign commit_o.illegal = wb.illegal;

endmodule

// File: hdl/rv_isa_pkg.sv
// rv64i integer subset encodings, alu operations and instruction field layout
package rv_isa_pkg;

    parameter int XLEN       = 64;
    parameter int REG_ADDR_W = 5;
    parameter int INST_W     = 32;

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // funct3 per alu group
    parameter logic [2:0] F3_ADD_SUB = 3'b000;
    parameter logic [2:0] F3_SLL     = 3'b001;
    parameter logic [2:0] F3_SLT     = 3'b010;
    parameter logic [2:0] F3_SLTU    = 3'b011;
    parameter logic [2:0] F3_XOR     = 3'b100;
    parameter logic [2:0] F3_SRL_SRA = 3'b101;
    parameter logic [2:0] F3_OR      = 3'b110;
    parameter logic [2:0] F3_AND     = 3'b111;

    parameter logic [6:0] FUNCT7_ALT = 7'b0100000; // sub / sra

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    // instruction field positions
    parameter int OPC_LSB = 0;
    parameter int RD_LSB  = 7;
    parameter int F3_LSB  = 12;
    parameter int RS1_LSB = 15;
    parameter int RS2_LSB = 20;
    parameter int F7_LSB  = 25;

    parameter logic [INST_W-1:0] NOP_INST = 32'h0000_0013; // addi x0,x0,0

endpackage

// File: hdl/stage_reg.sv
// pipeline register with valid bit, generic over the payload type
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // payload only follows a valid beat
    always_ff @(posedge clk) begin
        if (valid_i) begin
            data_o <= data_i;
        end
    end

endmodule

// File: test/rv_core_stim.hex
// count, then program words, then records {illegal[79:72], rd[71:64], wdata[63:0]}
17
800000B7 // lui   x1, 0x80000
FFB00113 // addi  x2, x0, -5
00C10193 // addi  x3, x2, 12
00218233 // add   x4, x3, x2
403102B3 // sub   x5, x2, x3
00419333 // sll   x6, x3, x4
003123B3 // slt   x7, x2, x3
00313433 // sltu  x8, x2, x3
0020C4B3 // xor   x9, x1, x2
0040D533 // srl   x10, x1, x4
4040D5B3 // sra   x11, x1, x4
0051E633 // or    x12, x3, x5
0050F6B3 // and   x13, x1, x5
FFC12713 // slti  x14, x2, -4
FFF1B793 // sltiu x15, x3, -1
00318033 // add   x0, x3, x3
55506893 // ori   x17, x0, 0x555
7F04F913 // andi  x18, x9, 0x7f0
02819993 // slli  x19, x3, 40
0240DA13 // srli  x20, x1, 36
4240DA93 // srai  x21, x1, 36
00003183 // ld x3 opcode, not supported
0F01C813 // xori  x16, x3, 0xf0, x3 still 7
0001FFFFFFFF80000000
0002FFFFFFFFFFFFFFFB
00030000000000000007
00040000000000000002
0005FFFFFFFFFFFFFFF4
0006000000000000001C
00070000000000000001
00080000000000000000
0009000000007FFFFFFB
000A3FFFFFFFE0000000
000BFFFFFFFFE0000000
000CFFFFFFFFFFFFFFF7
000DFFFFFFFF80000000
000E0000000000000001
000F0000000000000001
00000000000000000000
00110000000000000555
001200000000000007F0
00130000070000000000
0014000000000FFFFFFF
0015FFFFFFFFFFFFFFFF
01000000000000000000
001000000000000000F7

// File: test/rv_core_sva.sv
// concurrent checks on the fetch handshake and the retire port of the core
`timescale 1ns/1ps

module rv_core_sva (
    input logic                        clk,
    input logic                        reset_i,
    input logic                        imem_req_o,
    input logic [rv_isa_pkg::XLEN-1:0] imem_addr_o,
    input logic                        imem_ack_i,
    input pipe_pkg::commit_t           commit_o
);

    int unsigned fail_count = 0; // failed checks so far

    // req stays up until the memory acks
    req_held: assert property (@(posedge clk) disable iff (reset_i)
        imem_req_o && !imem_ack_i |=> imem_req_o)
        else begin
            $error("imem_req_o dropped before imem_ack_i");
            fail_count++;
        end

    addr_stable: assert property (@(posedge clk) disable iff (reset_i)
        imem_req_o && !imem_ack_i |=> $stable(imem_addr_o))
        else begin
            $error("imem_addr_o changed while imem_req_o was high");
            fail_count++;
        end

    // four-phase, new req only after ack is released
    req_after_release: assert property (@(posedge clk) disable iff (reset_i)
        $rose(imem_req_o) |-> !imem_ack_i)
        else begin
            $error("imem_req_o rose while imem_ack_i was still high");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        reset_i ##1 reset_i |-> !commit_o.valid)
        else begin
            $error("commit_o.valid high during reset");
            fail_count++;
        end

endmodule

bind rv_core_top rv_core_sva u_sva (.*);

// File: test/tb_rv_core.sv
// testbench for the rv64i integer core, program and expected retires come from a hex file
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [63:0] RESET_PC  = 64'h0000_0000_8000_0000;
    localparam logic [31:0] NOP_WORD  = 32'h0000_0013; // addi x0,x0,0
    localparam int          MAX_WORDS = 128;

    logic              clk;
    logic              reset_i;
    logic              imem_req_o;
    logic [63:0]       imem_addr_o;
    logic              imem_ack_i;
    logic [31:0]       imem_rdata_i;
    pipe_pkg::commit_t commit_o;

    logic [79:0] stim [MAX_WORDS]; // count, program words, then {illegal, rd, wdata} records
    int          n_inst;
    int          n_fetch;
    int          n_retire;
    int          n_pass;
    int          n_errors;
    int          seed;

    rv_core_top #(.RESET_PC(RESET_PC)) dut_i (
        .clk(clk), .reset_i(reset_i),
        .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o),
        .imem_ack_i(imem_ack_i), .imem_rdata_i(imem_rdata_i),
        .commit_o(commit_o)
    );

    always #5 clk = ~clk;

    function automatic bit check_field(string name, logic [63:0] got, logic [63:0] exp);
        bit ok;
        ok = (got === exp);
        assert (ok) else $display("Mismatch %s: got %h expected %h", name, got, exp);
        return ok;
    endfunction

    // instruction memory, random wait before ack and before release
    task automatic serve_fetches();
        int          delay;
        logic [63:0] idx;
        forever begin
            @(posedge clk);
            if (imem_req_o && !imem_ack_i) begin
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                idx = (imem_addr_o - RESET_PC) >> 2;
                if (!check_field("imem_addr_o", imem_addr_o, RESET_PC + 64'(4 * n_fetch)))
                    n_errors++;
                imem_rdata_i <= (idx < 64'(n_inst)) ? stim[1 + idx][31:0] : NOP_WORD;
                imem_ack_i   <= 1'b1;
                n_fetch++;
                do begin
                    @(posedge clk);
                end while (imem_req_o); // hold ack until req drops
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                imem_ack_i <= 1'b0;
            end
        end
    endtask

    task automatic check_retire();
        logic [79:0] rec;
        logic [63:0] exp_pc;
        bit          ok;
        rec    = stim[1 + n_inst + n_retire];
        exp_pc = RESET_PC + 64'(4 * n_retire); // straight-line program
        ok  = check_field("commit_o.pc", commit_o.pc, exp_pc);
        ok &= check_field("commit_o.rd", 64'(commit_o.rd), 64'(rec[71:64]));
        ok &= check_field("commit_o.wdata", commit_o.wdata, rec[63:0]);
        ok &= check_field("commit_o.illegal", 64'(commit_o.illegal), 64'(rec[79:72]));
        if (ok) begin
            n_pass++;
        end else begin
            n_errors++;
        end
        $display("test %0d pc %h: %s", n_retire, exp_pc, ok ? "ok" : "failed");
        n_retire++;
    endtask

    always @(posedge clk) begin
        if (!reset_i && commit_o.valid && n_retire < n_inst) begin
            check_retire();
        end
    end

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        imem_ack_i   = 1'b0;
        imem_rdata_i = NOP_WORD;
        seed         = 32'h6245_ea57;
        n_fetch      = 0;
        n_retire     = 0;
        n_pass       = 0;
        n_errors     = 0;
        $readmemh("test/rv_core_stim.hex", stim);
        n_inst = int'(stim[0]);
        assert (n_inst > 0 && 2 * n_inst < MAX_WORDS) else begin
            $display("stimulus file gave no usable instruction count");
            n_errors++;
            n_inst = 0;
        end
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        // quiet right after reset
        if (!check_field("imem_req_o", 64'(imem_req_o), 64'd0))
            n_errors++;
        if (!check_field("commit_o.valid", 64'(commit_o.valid), 64'd0))
            n_errors++;
        fork
            serve_fetches();
            begin
                repeat (n_inst * 12 + 50) @(posedge clk);
                $display("retire stalled, %0d of %0d instructions retired", n_retire, n_inst);
                $display("** FAIL **");
                $finish;
            end
        join_none
        wait (n_retire == n_inst);
        @(posedge clk);
        n_errors += dut_i.u_sva.fail_count;
        $display("%0d of %0d tests passed, %0d errors", n_pass, n_inst, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog.f
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/stage_reg.sv
hdl/alu_unit.sv
hdl/rv_core_top.sv
test/rv_core_sva.sv
test/tb_rv_core.sv
